//--- logic/core_pkg.sv
package core_pkg;

    localparam int xlen       = 32;
    localparam int num_regs   = 16;
    localparam int dmem_words = 256;
    localparam int dmem_aw    = $clog2(dmem_words);

    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;
    // addi x0, x0, 0
    localparam logic [xlen-1:0] nop_inst = 32'h0000_0013;

    // major opcodes, inst[6:0]
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;

    typedef enum logic [4:0] {
        op_add, op_sub, op_and, op_or, op_xor, op_slt, op_sltu, op_sll, op_srl, op_sra,
        op_lui, op_auipc, op_jal, op_jalr,
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
        op_load, op_store, op_nop
    } op_e;

    // order matches funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        sz_byte, sz_half, sz_word
    } size_e;

    typedef struct packed {
        op_e             op;
        logic            use_imm;
        logic [3:0]      rs1;
        logic [3:0]      rs2;
        logic [3:0]      rd;
        logic            reg_write;
        logic [xlen-1:0] imm;
        size_e           size;
        logic            load_unsigned;
    } decoded_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic            reg_write;
        logic [3:0]      rd;
        logic [xlen-1:0] value;
    } retire_t;

endpackage

//--- logic/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import core_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            next_valid,
    input  logic [xlen-1:0] imem_data,
    output logic [xlen-1:0] inst,
    output logic            inst_valid
);

    // instruction register, loaded when the pc unit hands over a new pc
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            inst       <= nop_inst;
            inst_valid <= 1'b0;
        end else begin
            inst_valid <= next_valid;
            if (next_valid) begin
                inst <= imem_data;
            end
        end
    end

endmodule

//--- logic/decode_unit.sv
`timescale 1ns/1ps

module decode_unit import core_pkg::*; (
    input  logic [xlen-1:0] inst,
    output decoded_t        dec
);

    logic [6:0]      opcode;
    logic [2:0]      f3;
    logic [6:0]      f7;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;
    logic            regs_hi;

    assign opcode = inst[6:0];
    assign f3     = inst[14:12];
    assign f7     = inst[31:25];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // funct3 to alu operation, alt selects sub / sra
    function automatic op_e alu_op(input logic [2:0] fn, input logic alt);
        case (fn)
            3'd0:    return alt ? op_sub : op_add;
            3'd1:    return op_sll;
            3'd2:    return op_slt;
            3'd3:    return op_sltu;
            3'd4:    return op_xor;
            3'd5:    return alt ? op_sra : op_srl;
            3'd6:    return op_or;
            default: return op_and;
        endcase
    endfunction

    always_comb begin
        dec               = '0;
        dec.op            = op_nop;
        dec.rs1           = inst[18:15];
        dec.rs2           = inst[23:20];
        dec.rd            = inst[10:7];
        dec.size          = size_e'(f3[1:0]);
        dec.load_unsigned = f3[2];
        regs_hi           = 1'b0;
        case (opcode)
            opc_op: begin
                if (f7 == 7'b0 || (f7 == 7'b0100000 && (f3 == 3'd0 || f3 == 3'd5))) begin
                    dec.op = alu_op(f3, inst[30]);
                end
                regs_hi = inst[24] | inst[19] | inst[11];
            end
            opc_op_imm: begin
                dec.use_imm = 1'b1;
                dec.imm     = imm_i;
                if (f3 == 3'd1) begin
                    if (f7 == 7'b0) dec.op = op_sll;
                end else if (f3 == 3'd5) begin
                    if (f7 == 7'b0 || f7 == 7'b0100000) dec.op = alu_op(f3, inst[30]);
                end else begin
                    // no subtract with an immediate
                    dec.op = alu_op(f3, 1'b0);
                end
                regs_hi = inst[19] | inst[11];
            end
            opc_lui: begin
                dec.op  = op_lui;
                dec.imm = imm_u;
                regs_hi = inst[11];
            end
            opc_auipc: begin
                dec.op  = op_auipc;
                dec.imm = imm_u;
                regs_hi = inst[11];
            end
            opc_jal: begin
                dec.op  = op_jal;
                dec.imm = imm_j;
                regs_hi = inst[11];
            end
            opc_jalr: begin
                if (f3 == 3'd0) dec.op = op_jalr;
                dec.use_imm = 1'b1;
                dec.imm     = imm_i;
                regs_hi     = inst[19] | inst[11];
            end
            opc_branch: begin
                case (f3)
                    3'd0:    dec.op = op_beq;
                    3'd1:    dec.op = op_bne;
                    3'd4:    dec.op = op_blt;
                    3'd5:    dec.op = op_bge;
                    3'd6:    dec.op = op_bltu;
                    3'd7:    dec.op = op_bgeu;
                    default: dec.op = op_nop;
                endcase
                dec.imm = imm_b;
                regs_hi = inst[24] | inst[19];
            end
            opc_load: begin
                if (f3 != 3'd3 && f3 != 3'd6 && f3 != 3'd7) dec.op = op_load;
                dec.use_imm = 1'b1;
                dec.imm     = imm_i;
                regs_hi     = inst[19] | inst[11];
            end
            opc_store: begin
                if (f3 <= 3'd2) dec.op = op_store;
                dec.use_imm = 1'b1;
                dec.imm     = imm_s;
                regs_hi     = inst[24] | inst[19];
            end
            default: dec.op = op_nop;
        endcase
        // x16..x31 do not exist on rv32e
        if (regs_hi) begin
            dec.op = op_nop;
        end
        dec.reg_write = !(dec.op inside {op_store, op_nop, op_beq, op_bne,
                                         op_blt, op_bge, op_bltu, op_bgeu});
    end

endmodule

//--- logic/reg_file.sv
`timescale 1ns/1ps

module reg_file import core_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            wen,
    input  logic [3:0]      waddr,
    input  logic [xlen-1:0] wdata,
    input  logic [3:0]      raddr1,
    input  logic [3:0]      raddr2,
    output logic [xlen-1:0] rdata1,
    output logic [xlen-1:0] rdata2
);

    logic [xlen-1:0] regs [num_regs];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != 4'd0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

//--- logic/exec_unit.sv
`timescale 1ns/1ps

module exec_unit import core_pkg::*; (
    input  decoded_t        dec,
    input  logic [xlen-1:0] rs1_data,
    input  logic [xlen-1:0] rs2_data,
    input  logic [xlen-1:0] pc,
    output logic [xlen-1:0] result,
    output logic            taken
);

    logic [xlen-1:0] opb;
    logic [4:0]      shamt;

    assign opb   = dec.use_imm ? dec.imm : rs2_data;
    assign shamt = opb[4:0];

    always_comb begin
        case (dec.op)
            op_sub:   result = rs1_data - opb;
            op_and:   result = rs1_data & opb;
            op_or:    result = rs1_data | opb;
            op_xor:   result = rs1_data ^ opb;
            op_slt:   result = {31'b0, $signed(rs1_data) < $signed(opb)};
            op_sltu:  result = {31'b0, rs1_data < opb};
            op_sll:   result = rs1_data << shamt;
            op_srl:   result = rs1_data >> shamt;
            op_sra:   result = $unsigned($signed(rs1_data) >>> shamt);
            op_lui:   result = dec.imm;
            op_auipc: result = pc + dec.imm;
            // add, and the effective address of loads and stores
            default:  result = rs1_data + opb;
        endcase
    end

    // branches compare the two registers directly
    always_comb begin
        case (dec.op)
            op_beq:          taken = rs1_data == rs2_data;
            op_bne:          taken = rs1_data != rs2_data;
            op_blt:          taken = $signed(rs1_data) < $signed(rs2_data);
            op_bge:          taken = $signed(rs1_data) >= $signed(rs2_data);
            op_bltu:         taken = rs1_data < rs2_data;
            op_bgeu:         taken = rs1_data >= rs2_data;
            op_jal, op_jalr: taken = 1'b1;
            default:         taken = 1'b0;
        endcase
    end

endmodule

//--- logic/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit import core_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            inst_valid,
    input  decoded_t        dec,
    input  logic [xlen-1:0] addr,
    input  logic [xlen-1:0] store_data,
    output logic [xlen-1:0] load_data,
    output logic            exec_done
);

    logic [xlen-1:0]    mem [dmem_words];
    logic [dmem_aw-1:0] idx;
    logic [3:0]         be;
    logic [xlen-1:0]    wd;
    logic [xlen-1:0]    rword;
    logic [xlen-1:0]    shifted;

    assign idx = addr[dmem_aw+1:2];

    // byte lanes and replicated store data
    always_comb begin
        case (dec.size)
            sz_byte: begin
                be = 4'b0001 << addr[1:0];
                wd = {4{store_data[7:0]}};
            end
            sz_half: begin
                be = addr[1] ? 4'b1100 : 4'b0011;
                wd = {2{store_data[15:0]}};
            end
            default: begin
                be = 4'b1111;
                wd = store_data;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exec_done <= 1'b0;
            for (int i = 0; i < dmem_words; i++) begin
                mem[i] <= '0;
            end
        end else begin
            exec_done <= inst_valid;
            if (inst_valid && dec.op == op_store) begin
                for (int lane = 0; lane < 4; lane++) begin
                    if (be[lane]) mem[idx][8*lane +: 8] <= wd[8*lane +: 8];
                end
            end
        end
    end

    // registered read, valid while exec_done is high
    always_ff @(posedge clk) begin
        if (inst_valid && dec.op == op_load) begin
            rword <= mem[idx];
        end
    end

    // dec and addr hold until the pc moves, so lane select can stay combinational
    assign shifted = (dec.size == sz_half) ? rword >> {addr[1], 4'b0000}
                                           : rword >> {addr[1:0], 3'b000};

    always_comb begin
        case (dec.size)
            sz_byte: load_data = {{24{shifted[7] & ~dec.load_unsigned}}, shifted[7:0]};
            sz_half: load_data = {{16{shifted[15] & ~dec.load_unsigned}}, shifted[15:0]};
            default: load_data = rword;
        endcase
    end

endmodule

//--- logic/pc_unit.sv
`timescale 1ns/1ps

module pc_unit import core_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            exec_done,
    input  decoded_t        dec,
    input  logic            taken,
    input  logic [xlen-1:0] rs1_data,
    output logic [xlen-1:0] pc,
    output logic            next_valid
);

    logic [xlen-1:0] next_pc;
    logic [xlen-1:0] jalr_target;

    assign jalr_target = rs1_data + dec.imm;

    always_comb begin
        if (dec.op == op_jalr) begin
            next_pc = {jalr_target[xlen-1:1], 1'b0};
        end else if (taken) begin
            // jal or a taken branch
            next_pc = pc + dec.imm;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    // next_valid sits high through reset, so the first fetch
    // happens on the first edge after release
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc         <= reset_pc;
            next_valid <= 1'b1;
        end else begin
            next_valid <= exec_done;
            if (exec_done) begin
                pc <= next_pc;
            end
        end
    end

endmodule

//--- logic/core_top.sv
`timescale 1ns/1ps

module core_top import core_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    output logic [xlen-1:0] imem_addr,
    input  logic [xlen-1:0] imem_data,
    output retire_t         retire
);

    logic [xlen-1:0] pc;
    logic [xlen-1:0] inst;
    logic            next_valid;
    logic            inst_valid;
    logic            exec_done;
    decoded_t        dec;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] result;
    logic            taken;
    logic [xlen-1:0] load_data;
    logic [xlen-1:0] wb_data;
    logic            wr_real;

    assign imem_addr = pc;

    fetch_unit u_fetch (
        .clk        (clk       ),
        .arst_n     (arst_n    ),
        .next_valid (next_valid),
        .imem_data  (imem_data ),
        .inst       (inst      ),
        .inst_valid (inst_valid)
    );

    decode_unit u_decode (
        .inst (inst),
        .dec  (dec )
    );

    reg_file u_reg (
        .clk    (clk                    ),
        .arst_n (arst_n                 ),
        .wen    (exec_done & dec.reg_write),
        .waddr  (dec.rd                 ),
        .wdata  (wb_data                ),
        .raddr1 (dec.rs1                ),
        .raddr2 (dec.rs2                ),
        .rdata1 (rs1_data               ),
        .rdata2 (rs2_data               )
    );

    exec_unit u_exec (
        .dec      (dec     ),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .pc       (pc      ),
        .result   (result  ),
        .taken    (taken   )
    );

    load_store_unit u_lsu (
        .clk        (clk       ),
        .arst_n     (arst_n    ),
        .inst_valid (inst_valid),
        .dec        (dec       ),
        .addr       (result    ),
        .store_data (rs2_data  ),
        .load_data  (load_data ),
        .exec_done  (exec_done )
    );

    pc_unit u_pc (
        .clk        (clk       ),
        .arst_n     (arst_n    ),
        .exec_done  (exec_done ),
        .dec        (dec       ),
        .taken      (taken     ),
        .rs1_data   (rs1_data  ),
        .pc         (pc        ),
        .next_valid (next_valid)
    );

    // writeback select
    always_comb begin
        case (dec.op)
            op_load:         wb_data = load_data;
            op_jal, op_jalr: wb_data = pc + 32'd4;
            default:         wb_data = result;
        endcase
    end

    // x0 as destination counts as no write
    assign wr_real = dec.reg_write && (dec.rd != 4'd0);

    always_comb begin
        retire.valid     = exec_done;
        retire.pc        = pc;
        retire.reg_write = wr_real;
        retire.rd        = dec.rd;
        retire.value     = wr_real ? wb_data : '0;
    end

endmodule

//--- dv/core_properties.sv
`timescale 1ns/1ps

module core_properties import core_pkg::*; (
    input logic    clk,
    input logic    arst_n,
    input logic    next_valid,
    input logic    inst_valid,
    input logic    exec_done,
    input retire_t retire
);

    // running count of assertion failures, summed into the closing line
    int fail_count = 0;

    // only one stage of the ring is active at a time
    strobe_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0({next_valid, inst_valid, exec_done}))
        else begin
            fail_count++;
            $error("more than one strobe of the ring is high");
        end

    fetch_follows: assert property (@(posedge clk) disable iff (!arst_n)
        next_valid |=> inst_valid)
        else begin
            fail_count++;
            $error("inst_valid did not follow next_valid");
        end

    exec_follows: assert property (@(posedge clk) disable iff (!arst_n)
        inst_valid |=> exec_done)
        else begin
            fail_count++;
            $error("exec_done did not follow inst_valid");
        end

    // nothing retires while the core is held in reset
    quiet_in_reset: assert property (@(posedge clk) !arst_n |-> !retire.valid)
        else begin
            fail_count++;
            $error("retire.valid high during reset");
        end

endmodule

bind core_top core_properties u_props (
    .clk        (clk       ),
    .arst_n     (arst_n    ),
    .next_valid (next_valid),
    .inst_valid (inst_valid),
    .exec_done  (exec_done ),
    .retire     (retire    )
);

//--- dv/core_tb.sv
`timescale 1ns/1ps

module core_tb import core_pkg::*; ();

    localparam int n_retires    = 200;
    localparam int reset_cycles = 8;
    localparam int rom_words    = 64;
    localparam int max_cycles   = n_retires * 3 + reset_cycles + 50;

    logic            clk;
    logic            arst_n;
    logic [xlen-1:0] imem_addr;
    logic [xlen-1:0] imem_data;
    retire_t         retire;

    logic [xlen-1:0] rom [rom_words];
    // instruction-set model state
    logic [xlen-1:0] m_regs [num_regs];
    logic [xlen-1:0] m_mem [dmem_words];
    logic [xlen-1:0] m_pc;
    retire_t         expected;

    int seed = 55731;
    int cycle = 0;
    int last_retire = 0;
    int n_retired = 0;
    int value_errors = 0;
    int other_errors = 0;

    core_top dut0 (
        .clk       (clk      ),
        .arst_n    (arst_n   ),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .retire    (retire   )
    );

    // program rom, read combinationally
    assign imem_data = rom[imem_addr[7:2]];

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic logic [31:0] pick(input int unsigned n);
        return {$random(seed)} % n;
    endfunction

    function automatic logic [31:0] enc_r(input logic [31:0] f7, rs2, rs1, f3, rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opc_op};
    endfunction

    function automatic logic [31:0] enc_i(input logic [31:0] imm, rs1, f3, rd,
                                          input logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [31:0] imm, rs2, rs1, f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], opc_store};
    endfunction

    function automatic logic [31:0] enc_b(input logic [31:0] imm, rs2, rs1, f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                opc_branch};
    endfunction

    function automatic logic [31:0] enc_u(input logic [31:0] imm, rd, input logic [6:0] opc);
        return {imm[19:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] enc_j(input logic [31:0] imm, rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], opc_jal};
    endfunction

    // a few words at each end of data memory, so loads hit earlier stores
    function automatic logic [31:0] offset_for(input logic [31:0] f3);
        logic [31:0] base;
        base = (pick(2) == 0) ? 4 * pick(4) : 1008 + 4 * pick(4);
        case (f3[1:0])
            2'd0:    return base + pick(4);
            2'd1:    return base + 2 * pick(2);
            default: return base;
        endcase
    endfunction

    task automatic gen_program();
        int          i;
        logic [31:0] kind, f3, rd, rs1, rs2, imm, n, jr;
        i = 0;
        while (i < rom_words - 1) begin
            kind = pick(11);
            f3   = pick(8);
            rd   = pick(num_regs);
            rs1  = pick(num_regs);
            rs2  = pick(num_regs);
            imm  = pick(4096);
            n    = 2 + pick(3);
            if (i + n > rom_words - 1) n = rom_words - 1 - i;
            case (kind)
                0, 1, 2: begin
                    // sub and sra live on funct3 0 and 5
                    imm = (f3 == 0 || f3 == 5) ? pick(2) * 32 : 0;
                    rom[i] = enc_r(imm, rs2, rs1, f3, rd);
                end
                3, 4: begin
                    if (f3 == 1) imm = pick(32);
                    else if (f3 == 5) imm = pick(2) * 1024 + pick(32);
                    rom[i] = enc_i(imm, rs1, f3, rd, opc_op_imm);
                end
                5: rom[i] = enc_u(pick(1 << 20), rd, (pick(2) == 0) ? opc_lui : opc_auipc);
                6: begin
                    f3 = (f3 == 3 || f3 >= 6) ? 2 : f3;
                    rom[i] = enc_i(offset_for(f3), 0, f3, rd, opc_load);
                end
                7: begin
                    f3 = pick(3);
                    rom[i] = enc_s(offset_for(f3), rs2, 0, f3);
                end
                8: begin
                    if (f3 == 2 || f3 == 3) f3 = 0;
                    rom[i] = enc_b(n * 4, rs2, rs1, f3);
                end
                9: rom[i] = enc_j(n * 4, rd);
                default: begin
                    if (i >= rom_words - 2) begin
                        rom[i] = enc_i(imm, rs1, 0, rd, opc_op_imm);
                    end else begin
                        // addi sets the target, jalr jumps through it
                        jr = 1 + pick(num_regs - 1);
                        if (i + 1 + n > rom_words - 1) n = rom_words - 2 - i;
                        rom[i] = enc_i((i + 1 + n) * 4, 0, 0, jr, opc_op_imm);
                        rom[i + 1] = enc_i(pick(2), jr, 0, rd, opc_jalr);
                        i++;
                    end
                end
            endcase
            i++;
        end
        // park on jal x0, 0
        rom[rom_words - 1] = enc_j(0, 0);
    endtask

    function automatic logic [31:0] alu(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // one instruction of the model, returns what the core should retire
    function automatic retire_t iss_step();
        logic [31:0] inst, a, b, imm_i, imm_s, imm_b, imm_u, imm_j;
        logic [31:0] val, npc, addr, word;
        logic [2:0]  f3;
        logic        wr;
        logic        take;
        retire_t     r;
        inst  = rom[m_pc[7:2]];
        f3    = inst[14:12];
        a     = m_regs[inst[18:15]];
        b     = m_regs[inst[23:20]];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_u = {inst[31:12], 12'd0};
        imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        val   = 32'd0;
        wr    = 1'b1;
        take  = 1'b0;
        npc   = m_pc + 32'd4;
        addr  = a + ((inst[6:0] == opc_store) ? imm_s : imm_i);
        word  = m_mem[addr[9:2]];
        case (inst[6:0])
            opc_op:     val = alu(f3, inst[30], a, b);
            opc_op_imm: val = alu(f3, f3 == 3'd5 && inst[30], a, imm_i);
            opc_lui:    val = imm_u;
            opc_auipc:  val = m_pc + imm_u;
            opc_jal: begin
                val = m_pc + 32'd4;
                npc = m_pc + imm_j;
            end
            opc_jalr: begin
                val = m_pc + 32'd4;
                npc = (a + imm_i) & ~32'd1;
            end
            opc_branch: begin
                wr = 1'b0;
                case (f3)
                    3'd0:    take = a == b;
                    3'd1:    take = a != b;
                    3'd4:    take = $signed(a) < $signed(b);
                    3'd5:    take = $signed(a) >= $signed(b);
                    3'd6:    take = a < b;
                    default: take = a >= b;
                endcase
                if (take) npc = m_pc + imm_b;
            end
            opc_load: begin
                word = word >> {addr[1:0], 3'b000};
                case (f3)
                    3'd0:    val = {{24{word[7]}}, word[7:0]};
                    3'd1:    val = {{16{word[15]}}, word[15:0]};
                    3'd4:    val = {24'd0, word[7:0]};
                    3'd5:    val = {16'd0, word[15:0]};
                    default: val = word;
                endcase
            end
            opc_store: begin
                wr = 1'b0;
                case (f3)
                    3'd0:    m_mem[addr[9:2]][{addr[1:0], 3'b000} +: 8] = b[7:0];
                    3'd1:    m_mem[addr[9:2]][{addr[1], 4'b0000} +: 16] = b[15:0];
                    default: m_mem[addr[9:2]] = b;
                endcase
            end
            default: wr = 1'b0;
        endcase
        wr = wr && (inst[11:7] != 5'd0);
        if (wr) m_regs[inst[10:7]] = val;
        r.valid     = 1'b1;
        r.pc        = m_pc;
        r.reg_write = wr;
        r.rd        = inst[10:7];
        r.value     = wr ? val : 32'd0;
        m_pc        = npc;
        return r;
    endfunction

    task automatic check_word(input string name, input logic [xlen-1:0] got, exp);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_retire(input retire_t got, exp);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] retire got %h expected %h", got, exp);
        end
    endtask

    task automatic finish_run();
        $display("retired %0d, value errors %0d, other errors %0d, assertion failures %0d",
                 n_retired, value_errors, other_errors, dut0.u_props.fail_count);
        if (value_errors + other_errors + dut0.u_props.fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    // sampled mid-cycle, away from the clock edge
    always @(negedge clk) begin
        if (!arst_n && retire.valid) begin
            other_errors++;
            $display("a retire was reported while reset was asserted");
        end else if (retire.valid) begin
            // next_valid, inst_valid, then exec_done after release
            if (n_retired == 0 && cycle != reset_cycles + 2) begin
                other_errors++;
                $display("first retire came in cycle %0d instead of cycle %0d",
                         cycle, reset_cycles + 2);
            end
            if (n_retired > 0 && cycle - last_retire != 3) begin
                other_errors++;
                $display("retires %0d cycles apart instead of 3", cycle - last_retire);
            end
            expected = iss_step();
            check_word("retire.pc", retire.pc, expected.pc);
            check_word("imem_addr", imem_addr, expected.pc);
            check_word("retire.value", retire.value, expected.value);
            check_retire(retire, expected);
            last_retire = cycle;
            n_retired++;
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle == max_cycles) begin
            other_errors++;
            $display("timeout after %0d cycles with only %0d of %0d instructions retired",
                     cycle, n_retired, n_retires);
            finish_run();
        end
    end

    initial begin
        arst_n = 1'b0;
        gen_program();
        for (int r = 0; r < num_regs; r++) begin
            m_regs[r] = '0;
        end
        for (int w = 0; w < dmem_words; w++) begin
            m_mem[w] = '0;
        end
        m_pc = reset_pc;
        repeat (reset_cycles) @(posedge clk);
        #1 arst_n = 1'b1;
        wait (n_retired == n_retires);
        @(posedge clk);
        finish_run();
    end

endmodule

//--- all.f
logic/core_pkg.sv
logic/fetch_unit.sv
logic/decode_unit.sv
logic/reg_file.sv
logic/exec_unit.sv
logic/load_store_unit.sv
logic/pc_unit.sv
logic/core_top.sv
dv/core_properties.sv
dv/core_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module core_tb -f all.f -o core_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/core_sim +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" "$log"; then
    exit 1
fi
exit 0
